// ==== source/cpuPkg.sv ====
package cpuPkg;

	// instruction opcodes, top nibble of the word.
	typedef enum logic [3:0]
	{
		ADD  = 4'h0, // rd = ra + rb.
		SUB  = 4'h1, // rd = ra - rb.
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		ADDI = 4'h5, // rd = rd + imm.
		LDI  = 4'h6, // rd = imm.
		LD   = 4'h7, // rd = mem[ra].
		ST   = 4'h8, // mem[ra] = rd.
		SHL  = 4'h9, // rd = ra << rb, one bit per cycle.
		SHR  = 4'ha,
		JZ   = 4'hb, // pc = imm when rd is zero.
		HALT = 4'hc
	} opcodeT;

	// one instruction word, two views of the operand bits.
	typedef union packed
	{
		struct packed
		{
			opcodeT opcode;
			logic [3:0] rd;
			logic [3:0] ra;
			logic [3:0] rb;
		} regForm;
		struct packed
		{
			opcodeT opcode;
			logic [3:0] rd;
			logic [7:0] imm; // zero extended.
		} immForm;
	} instrT;

	typedef enum logic [2:0]
	{
		opAdd, opSub, opAnd, opOr, opXor, opPassA, opShl, opShr
	} aluOpT;

	// register file steering, vectors are one bit per register.
	typedef struct packed
	{
		logic [15:0] loadAluB;  // active low.
		logic [15:0] loadMemB;  // active low.
		logic [15:0] loadPipeB; // active low.
		logic [15:0] incB;      // active low.
		logic [3:0] aluASel;
		logic [3:0] aluBSel;
		logic [3:0] memSel;     // store data source.
		logic [3:0] addrSel;    // bus address source.
		logic memEnB;           // low drives memData.
		logic aluBFromPipeB;    // low takes the constant onto alu b.
	} rfCtrlT;

	// wishbone classic master outputs.
	typedef struct packed
	{
		logic [15:0] adr;
		logic [15:0] dat;
		logic we;
		logic cyc;
		logic stb;
	} wbReqT;

	localparam logic [3:0] pcIndex = 4'd15; // r15 is the pc.

endpackage

// ==== source/register.sv ====
module register
#(
	parameter int bits = 16
)
(
	input  logic CLK,
	input  logic rst,
	input  logic [bits-1:0] inAlu,
	input  logic loadAluB,         // active low.
	input  logic [bits-1:0] inMem,
	input  logic loadMemB,         // active low.
	input  logic [bits-1:0] inPipe,
	input  logic loadPipeB,        // active low.
	input  logic incB,             // active low.
	output logic [bits-1:0] q
);

	// alu beats memory beats constant beats increment.
	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			q <= '0;
		end
		else if (!loadAluB)
		begin
			q <= inAlu;
		end
		else if (!loadMemB)
		begin
			q <= inMem; // load data.
		end
		else if (!loadPipeB)
		begin
			q <= inPipe; // immediate.
		end
		else if (!incB)
		begin
			q <= q + 1'b1; // pc step.
		end
	end

endmodule

// ==== source/registerFile.sv ====
module registerFile
#(
	parameter int regBits = 4,
	parameter int bits = 16
)
(
	input  logic CLK,
	input  logic rst,
	input  cpuPkg::rfCtrlT ctrl,
	input  logic [bits-1:0] inAlu,
	input  logic [bits-1:0] inMem,
	input  logic [bits-1:0] inPipe,
	output logic [bits-1:0] aluA,
	output logic [bits-1:0] aluB,
	output logic [bits-1:0] memData,
	output logic [bits-1:0] memAddr
);

	localparam int regCount = 2**regBits;

	logic [bits-1:0] regOut [regCount];
	logic [regBits-1:0] aSel;
	logic [regBits-1:0] bSel;
	logic [regBits-1:0] mSel;
	logic [regBits-1:0] adrSel;

	// selects sized to the file.
	assign aSel = ctrl.aluASel[regBits-1:0];
	assign bSel = ctrl.aluBSel[regBits-1:0];
	assign mSel = ctrl.memSel[regBits-1:0];
	assign adrSel = ctrl.addrSel[regBits-1:0];

	// read ports, all combinational.
	assign aluA = regOut[aSel];
	assign aluB = (ctrl.aluBFromPipeB == 1'b0) ? inPipe : regOut[bSel];
	assign memData = (ctrl.memEnB == 1'b0) ? regOut[mSel] : '0; // idle bus data is zero.
	assign memAddr = regOut[adrSel];

	genvar j;
	generate
		for (j = 0; j < regCount; j++)
		begin : genRegs
			register #(
				.bits(bits)
			) u_reg (
				.CLK(CLK),
				.rst(rst),
				.inAlu(inAlu),
				.loadAluB(ctrl.loadAluB[j]),
				.inMem(inMem),
				.loadMemB(ctrl.loadMemB[j]),
				.inPipe(inPipe),
				.loadPipeB(ctrl.loadPipeB[j]),
				.incB(ctrl.incB[j]),
				.q(regOut[j])
			);
		end
	endgenerate

endmodule

// ==== source/alu.sv ====
module alu
#(
	parameter int bits = 16
)
(
	input  cpuPkg::aluOpT op,
	input  logic [bits-1:0] a,
	input  logic [bits-1:0] b,
	output logic [bits-1:0] result,
	output logic zero
);
	import cpuPkg::*;

	always_comb
	begin
		case (op)
			opAdd:
			begin
				result = a + b; // carry dropped.
			end
			opSub:
			begin
				result = a - b;
			end
			opAnd:
			begin
				result = a & b;
			end
			opOr:
			begin
				result = a | b; // also the jump target path.
			end
			opXor:
			begin
				result = a ^ b;
			end
			opShl:
			begin
				result = {a[bits-2:0], 1'b0};
			end
			opShr:
			begin
				result = {1'b0, a[bits-1:1]};
			end
			default:
			begin
				result = a; // pass for shift copy.
			end
		endcase
	end

	// flag is on operand a, the tested register.
	assign zero = (a == '0);

endmodule

// ==== source/shiftCounter.sv ====
module shiftCounter
(
	input  logic CLK,
	input  logic rst,
	input  logic load,
	input  logic [3:0] count,
	input  logic step,
	output logic done
);

	logic [3:0] remaining; // shift steps left.

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			remaining <= '0;
		end
		else if (load)
		begin
			remaining <= count;
		end
		else if (step && remaining != '0)
		begin
			remaining <= remaining - 1'b1; // stops at zero.
		end
	end

	// high whenever nothing is left to shift.
	assign done = (remaining == '0);

endmodule

// ==== source/controlFsm.sv ====
module controlFsm
#(
	parameter int regBits = 4,
	parameter int bits = 16
)
(
	input  logic CLK,
	input  logic rst,
	output cpuPkg::wbReqT wbReq,
	input  logic [bits-1:0] wbDatI,
	input  logic wbAck,
	input  logic [bits-1:0] memAddr,  // bus address from the file.
	input  logic [bits-1:0] memData,  // store data from the file.
	input  logic zero,
	input  logic shiftDone,
	output cpuPkg::rfCtrlT rfCtrl,
	output cpuPkg::aluOpT aluOp,
	output logic [bits-1:0] pipeData,
	output logic shiftLoad,
	output logic shiftStep,
	output logic halted
);
	import cpuPkg::*;

	typedef enum logic [2:0] {sFetch, sExecute, sMemory, sShiftCopy, sShift, sHalt} stateT;

	stateT state;
	instrT ir;      // current instruction.
	instrT fetched; // word on the bus.
	opcodeT opcode;
	logic busy;     // cyc and stb.
	logic ackSeen;
	logic [regBits-1:0] rd;
	logic [regBits-1:0] ra;
	logic [regBits-1:0] rb;

	// one cleared bit per register.
	function automatic logic [15:0] strobeB(input logic [regBits-1:0] idx);
		strobeB = ~(16'h0001 << idx);
	endfunction

	assign fetched = wbDatI;
	assign ackSeen = busy & wbAck;
	assign opcode = ir.regForm.opcode;
	assign rd = ir.regForm.rd[regBits-1:0]; // same bits in both forms.
	assign ra = ir.regForm.ra[regBits-1:0];
	assign rb = ir.regForm.rb[regBits-1:0];
	assign pipeData = {{(bits-8){1'b0}}, ir.immForm.imm};

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			state <= sFetch;
			busy <= 1'b0;
		end
		else
		begin
			// strobes drop after ack, rise again one cycle later.
			if (busy)
				busy <= ~wbAck;
			else if (state == sFetch || state == sMemory)
				busy <= 1'b1;
			case (state)
				sFetch:
				begin
					if (ackSeen)
					begin
						// decoded straight off the bus.
						case (fetched.regForm.opcode)
							LD, ST: state <= sMemory;
							SHL, SHR: state <= sShiftCopy;
							default: state <= sExecute;
						endcase
					end
				end
				sExecute: state <= (opcode == HALT) ? sHalt : sFetch;
				sMemory: state <= ackSeen ? sFetch : sMemory;
				sShiftCopy: state <= sShift;
				sShift: state <= shiftDone ? sFetch : sShift;
				default: state <= sHalt; // stuck until reset.
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (state == sFetch && ackSeen)
			ir <= fetched;
	end

	always_comb
	begin
		rfCtrl.loadAluB = '1;
		rfCtrl.loadMemB = '1;
		rfCtrl.loadPipeB = '1;
		rfCtrl.incB = '1;
		rfCtrl.aluASel = ra;
		rfCtrl.aluBSel = rb;
		rfCtrl.memSel = rd;
		rfCtrl.addrSel = pcIndex;
		rfCtrl.memEnB = 1'b1;
		rfCtrl.aluBFromPipeB = 1'b1;
		aluOp = opPassA;
		case (state)
			sFetch:
			begin
				if (ackSeen)
					rfCtrl.incB = strobeB(pcIndex); // pc past the fetched word.
			end
			sExecute:
			begin
				case (opcode)
					ADD, SUB, AND, OR, XOR:
					begin
						rfCtrl.loadAluB = strobeB(rd);
						case (opcode)
							SUB: aluOp = opSub;
							AND: aluOp = opAnd;
							OR: aluOp = opOr;
							XOR: aluOp = opXor;
							default: aluOp = opAdd;
						endcase
					end
					ADDI:
					begin
						rfCtrl.aluASel = rd;
						rfCtrl.aluBFromPipeB = 1'b0;
						rfCtrl.loadAluB = strobeB(rd);
						aluOp = opAdd;
					end
					LDI: rfCtrl.loadPipeB = strobeB(rd);
					JZ:
					begin
						// a is zero when taken, so or hands over the target.
						rfCtrl.aluASel = rd;
						rfCtrl.aluBFromPipeB = 1'b0;
						aluOp = opOr;
						if (zero)
							rfCtrl.loadAluB = strobeB(pcIndex);
					end
					default: aluOp = opPassA; // halt and spare codes.
				endcase
			end
			sMemory:
			begin
				rfCtrl.addrSel = ra;
				if (opcode == ST)
				begin
					rfCtrl.memEnB = 1'b0; // rd onto the bus.
				end
				else if (ackSeen)
					rfCtrl.loadMemB = strobeB(rd); // read data in the ack cycle.
			end
			sShiftCopy:
			begin
				rfCtrl.loadAluB = strobeB(rd); // rd takes ra unshifted.
			end
			sShift:
			begin
				rfCtrl.aluASel = rd;
				aluOp = (opcode == SHL) ? opShl : opShr;
				if (!shiftDone)
					rfCtrl.loadAluB = strobeB(rd);
			end
			default: aluOp = opPassA;
		endcase
	end

	assign wbReq.cyc = busy;
	assign wbReq.stb = busy;
	assign wbReq.we = (state == sMemory) && (opcode == ST); // write only for a store.
	assign wbReq.adr = memAddr;
	assign wbReq.dat = memData;
	assign shiftLoad = (state == sShiftCopy); // count is rb.
	assign shiftStep = (state == sShift) && !shiftDone;
	assign halted = (state == sHalt);

endmodule

// ==== source/cpuCore.sv ====
module cpuCore
#(
	parameter int regBits = 4,
	parameter int bits = 16
)
(
	input  logic CLK,
	input  logic rst,
	output cpuPkg::wbReqT wbReq,
	input  logic [bits-1:0] wbDatI,
	input  logic wbAck,
	output logic halted
);
	import cpuPkg::*;

	rfCtrlT rfCtrl;
	aluOpT aluOp;
	logic [bits-1:0] pipeData;  // zero extended immediate.
	logic [bits-1:0] aluA;
	logic [bits-1:0] aluB;
	logic [bits-1:0] aluResult;
	logic [bits-1:0] memData;
	logic [bits-1:0] memAddr;
	logic zero;
	logic shiftLoad;
	logic shiftStep;
	logic shiftDone;

	controlFsm #(
		.regBits(regBits),
		.bits(bits)
	) u_fsm (
		.CLK(CLK),
		.rst(rst),
		.wbReq(wbReq),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.memAddr(memAddr),
		.memData(memData),
		.zero(zero),
		.shiftDone(shiftDone),
		.rfCtrl(rfCtrl),
		.aluOp(aluOp),
		.pipeData(pipeData),
		.shiftLoad(shiftLoad),
		.shiftStep(shiftStep),
		.halted(halted)
	);

	registerFile #(
		.regBits(regBits),
		.bits(bits)
	) u_regFile (
		.CLK(CLK),
		.rst(rst),
		.ctrl(rfCtrl),
		.inAlu(aluResult),
		.inMem(wbDatI),       // load data straight off the bus.
		.inPipe(pipeData),
		.aluA(aluA),
		.aluB(aluB),
		.memData(memData),
		.memAddr(memAddr)
	);

	alu #(
		.bits(bits)
	) u_alu (
		.op(aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.zero(zero)
	);

	// low nibble of the constant is the rb field.
	shiftCounter u_shiftCounter (
		.CLK(CLK),
		.rst(rst),
		.load(shiftLoad),
		.count(pipeData[3:0]),
		.step(shiftStep),
		.done(shiftDone)
	);

endmodule

// ==== tests/cpuCore_chk.sv ====
module cpuCoreChk
(
	input  logic CLK,
	input  logic rst,
	input  cpuPkg::wbReqT wbReq,
	input  logic wbAck,
	input  logic halted
);

	// strobe only inside a cycle.
	stbInCyc: assert property (@(posedge CLK) disable iff (rst) wbReq.stb |-> wbReq.cyc)
		else $error("wishbone stb is high while cyc is low");

	// request held until the slave answers.
	reqStable: assert property (@(posedge CLK) disable iff (rst)
		wbReq.stb && !wbAck |=> $stable(wbReq.adr) && $stable(wbReq.dat) && $stable(wbReq.we))
		else $error("wishbone request changed before ack");

	// a stopped core stays off the bus.
	quietHalt: assert property (@(posedge CLK) disable iff (rst) halted |-> !wbReq.cyc)
		else $error("bus cycle started after halt");

	stayHalted: assert property (@(posedge CLK) disable iff (rst) halted |=> halted)
		else $error("halted dropped without reset");

endmodule

// checker rides along with every core instance.
bind cpuCore cpuCoreChk u_chk
(
	.CLK(CLK),
	.rst(rst),
	.wbReq(wbReq),
	.wbAck(wbAck),
	.halted(halted)
);

// ==== tests/cpuCoreTb.sv ====
module cpuCoreTb;
	import cpuPkg::*;

	localparam int testCount = 6;
	localparam int cyclesPerTest = 400;
	localparam int cycleLimit = testCount * cyclesPerTest;
	localparam int haltLimit = 360; // program run, reset not included.

	logic CLK;
	logic rst;
	wbReqT wbReq;
	logic [15:0] wbDatI;
	logic wbAck;
	logic halted;

	logic [15:0] mem [256]; // 256 word slave.
	integer seed;
	int errorCount;
	int cycleCount;
	int busCycles;          // acked transfers.
	int waitLeft;           // wait states still due.
	logic pending;          // wait count drawn for this transfer.
	int loadAddr;           // next program slot.

	cpuCore #(
		.regBits(4),
		.bits(16)
	) u_dut (
		.CLK(CLK),
		.rst(rst),
		.wbReq(wbReq),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.halted(halted)
	);

	always #10 CLK = ~CLK;

	// slave model, answers on the falling edge.
	always @(negedge CLK)
	begin
		if (wbAck)
		begin
			wbAck = 1'b0; // single cycle ack.
			wbDatI = '0;
		end
		else if (wbReq.cyc && wbReq.stb)
		begin
			if (!pending)
			begin
				waitLeft = $random(seed) & 3; // 0 to 3 wait states.
				pending = 1'b1;
			end
			if (waitLeft == 0)
			begin
				pending = 1'b0;
				wbAck = 1'b1;
				busCycles++;
				if (wbReq.we)
					mem[wbReq.adr[7:0]] = wbReq.dat;
				else
					wbDatI = mem[wbReq.adr[7:0]];
			end
			else
				waitLeft--;
		end
	end

	always @(posedge CLK)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run went past %0d cycles, %0d errors", cycleLimit, errorCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] regWord(input opcodeT op, input int rd, input int ra,
		input int rb);
		return {op, rd[3:0], ra[3:0], rb[3:0]};
	endfunction

	function automatic logic [15:0] immWord(input opcodeT op, input int rd, input int imm);
		return {op, rd[3:0], imm[7:0]};
	endfunction

	// background word, differs for every address.
	function automatic logic [15:0] fillWord(input int addr);
		return {~addr[7:0], addr[7:0]};
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		assert (got === expected)
		else
		begin
			$display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic clearMemory;
		for (int i = 0; i < 256; i++)
			mem[i] = fillWord(i);
		loadAddr = 0;
	endtask

	task automatic putInstr(input logic [15:0] word);
		mem[loadAddr] = word;
		loadAddr++;
	endtask

	// sixteen reset cycles, bus and halt quiet throughout.
	task automatic resetCore;
		rst = 1'b1;
		repeat (16)
		begin
			@(negedge CLK);
			checkValue("wbReq.cyc", wbReq.cyc, 16'h0);
			checkValue("wbReq.stb", wbReq.stb, 16'h0);
			checkValue("halted", halted, 16'h0);
		end
		rst = 1'b0;
	endtask

	task automatic waitHalted(input string testName);
		int n;
		n = 0;
		while (!halted && n < haltLimit)
		begin
			@(negedge CLK);
			n++;
		end
		assert (halted)
		else
		begin
			$display("Error at %0t: %s program did not halt within %0d cycles",
				$time, testName, haltLimit);
			errorCount++;
		end
	endtask

	task automatic runProgram(input string testName);
		busCycles = 0;
		resetCore();
		waitHalted(testName);
	endtask

	task automatic testReset;
		int n;
		clearMemory();
		putInstr(immWord(HALT, 0, 0));
		busCycles = 0;
		resetCore();
		n = 0;
		while (!wbReq.cyc && n < 8)
		begin
			@(negedge CLK);
			n++;
		end
		assert (wbReq.cyc)
		else
		begin
			$display("Error at %0t: no fetch started after reset", $time);
			errorCount++;
		end
		checkValue("wbReq.adr", wbReq.adr, 16'h0000); // first fetch from zero.
		waitHalted("reset");
		checkValue("bus cycles", busCycles, 16'd1);
	endtask

	task automatic testAlu;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [15:0] r1;
		logic [15:0] expected [6];
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		r1 = a + c;
		expected[0] = r1;
		expected[1] = r1 + b;
		expected[2] = r1 - b; // wraps below zero.
		expected[3] = r1 & b;
		expected[4] = r1 | b;
		expected[5] = r1 ^ b;
		clearMemory();
		putInstr(immWord(LDI, 1, a));
		putInstr(immWord(LDI, 2, b));
		putInstr(immWord(ADDI, 1, c));
		putInstr(regWord(ADD, 3, 1, 2));
		putInstr(regWord(SUB, 4, 1, 2));
		putInstr(regWord(AND, 5, 1, 2));
		putInstr(regWord(OR, 6, 1, 2));
		putInstr(regWord(XOR, 7, 1, 2));
		putInstr(immWord(LDI, 8, 8'h80));
		for (int i = 0; i < 6; i++)
		begin
			putInstr(regWord(ST, (i == 0) ? 1 : i + 2, 8, 0)); // r1 then r3 to r7.
			putInstr(immWord(ADDI, 8, 1));
		end
		putInstr(immWord(HALT, 0, 0));
		runProgram("alu");
		for (int i = 0; i < 6; i++)
			checkValue($sformatf("mem[0x%h]", 8'h80 + i), mem[8'h80 + i], expected[i]);
	endtask

	task automatic testLoadStore;
		logic [15:0] data [4];
		clearMemory();
		for (int i = 0; i < 4; i++)
		begin
			data[i] = $random(seed);
			mem[8'h90 + i] = data[i];
		end
		putInstr(immWord(LDI, 1, 8'h90)); // source pointer.
		putInstr(immWord(LDI, 2, 8'ha0)); // target pointer.
		for (int i = 0; i < 4; i++)
		begin
			putInstr(regWord(LD, 3 + i, 1, 0));
			putInstr(regWord(ST, 3 + i, 2, 0));
			putInstr(immWord(ADDI, 1, 1));
			putInstr(immWord(ADDI, 2, 1));
		end
		putInstr(immWord(HALT, 0, 0));
		runProgram("load/store");
		for (int i = 0; i < 4; i++)
		begin
			checkValue($sformatf("mem[0x%h]", 8'ha0 + i), mem[8'ha0 + i], data[i]);
			checkValue($sformatf("mem[0x%h]", 8'h90 + i), mem[8'h90 + i], data[i]);
		end
	endtask

	task automatic testShift;
		logic [15:0] value;
		int counts [4];
		logic [15:0] expected [5];
		value[15:8] = $random(seed);
		value[7:0] = $random(seed);
		for (int i = 0; i < 4; i++)
			counts[i] = $random(seed) & 15;
		expected[0] = value;
		expected[1] = value << counts[0];
		expected[2] = value >> counts[1];
		expected[3] = value << counts[2];
		expected[4] = value >> counts[3];
		clearMemory();
		putInstr(immWord(LDI, 1, value[15:8]));
		putInstr(regWord(SHL, 1, 1, 8)); // high byte into place.
		putInstr(immWord(ADDI, 1, value[7:0]));
		for (int i = 0; i < 4; i++)
			putInstr(regWord(opcodeT'((i % 2 == 0) ? SHL : SHR), 2 + i, 1, counts[i]));
		putInstr(immWord(LDI, 8, 8'hb0));
		for (int i = 0; i < 5; i++)
		begin
			putInstr(regWord(ST, 1 + i, 8, 0));
			putInstr(immWord(ADDI, 8, 1));
		end
		putInstr(immWord(HALT, 0, 0));
		runProgram("shift");
		for (int i = 0; i < 5; i++)
			checkValue($sformatf("mem[0x%h]", 8'hb0 + i), mem[8'hb0 + i], expected[i]);
	endtask

	task automatic testJump;
		int n;
		n = ($random(seed) & 7) + 1; // loop trips.
		clearMemory();
		putInstr(immWord(LDI, 1, n));
		putInstr(immWord(LDI, 2, 0));
		putInstr(immWord(LDI, 3, 1));
		putInstr(immWord(JZ, 1, 7));      // 3: exit once r1 is spent.
		putInstr(regWord(SUB, 1, 1, 3));
		putInstr(immWord(ADDI, 2, 1));
		putInstr(immWord(JZ, 0, 3));      // r0 stays zero, always taken.
		putInstr(immWord(LDI, 8, 8'hc0)); // 7.
		putInstr(regWord(ST, 2, 8, 0));
		putInstr(immWord(JZ, 2, 13));     // r2 nonzero, falls through.
		putInstr(immWord(LDI, 4, 8'h5a));
		putInstr(immWord(ADDI, 8, 1));
		putInstr(regWord(ST, 4, 8, 0));
		putInstr(immWord(HALT, 0, 0));    // 13.
		runProgram("jump");
		checkValue("mem[0xc0]", mem[8'hc0], n);
		checkValue("mem[0xc1]", mem[8'hc1], 16'h005a);
	endtask

	task automatic testHalt;
		logic [7:0] x;
		x = $random(seed);
		clearMemory();
		putInstr(immWord(LDI, 1, x));
		putInstr(immWord(LDI, 8, 8'hd0));
		putInstr(regWord(ST, 1, 8, 0));
		putInstr(immWord(HALT, 0, 0));
		putInstr(immWord(ADDI, 8, 1)); // never reached.
		putInstr(regWord(ST, 1, 8, 0));
		putInstr(immWord(HALT, 0, 0));
		runProgram("halt");
		checkValue("bus cycles", busCycles, 16'd5); // four fetches and one store.
		repeat (40)
		begin
			@(negedge CLK);
			checkValue("halted", halted, 16'h1);
			checkValue("wbReq.cyc", wbReq.cyc, 16'h0);
		end
		checkValue("bus cycles", busCycles, 16'd5);
		checkValue("mem[0xd0]", mem[8'hd0], {8'h00, x});
		checkValue("mem[0xd1]", mem[8'hd1], fillWord(8'hd1));
	endtask

	initial
	begin
		CLK = 1'b0;
		rst = 1'b1;
		wbAck = 1'b0;
		wbDatI = '0;
		seed = 32'hc140;
		errorCount = 0;
		cycleCount = 0;
		busCycles = 0;
		waitLeft = 0;
		pending = 1'b0;
		loadAddr = 0;
		testReset();
		testAlu();
		testLoadStore();
		testShift();
		testJump();
		testHalt();
		$display("Tests done after %0d cycles, %0d errors", cycleCount, errorCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
source/cpuPkg.sv
source/register.sv
source/registerFile.sv
source/alu.sv
source/shiftCounter.sv
source/controlFsm.sv
source/cpuCore.sv
tests/cpuCore_chk.sv
tests/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - source/cpuPkg.sv
  - source/register.sv
  - source/registerFile.sv
  - source/alu.sv
  - source/shiftCounter.sv
  - source/controlFsm.sv
  - source/cpuCore.sv
  - target: test
    files:
      - tests/cpuCore_chk.sv
      - tests/cpuCoreTb.sv
